// File: sources.f
verilog/cbc_dec_pkg.sv
verilog/cbc_dec_ctrl.sv
verilog/block_capture.sv
verilog/core_bus_drive.sv
verilog/cbc_unchain.sv
verilog/pt_skid_buffer.sv
verilog/cbc_dec_top.sv
verification/cipher_core_model.sv
verification/cbc_dec_asserts.sv
verification/cbc_dec_tb.sv

// File: Bender.yml
package:
  name: cbc_dec

sources:
  - verilog/cbc_dec_pkg.sv
  - verilog/cbc_dec_ctrl.sv
  - verilog/block_capture.sv
  - verilog/core_bus_drive.sv
  - verilog/cbc_unchain.sv
  - verilog/pt_skid_buffer.sv
  - verilog/cbc_dec_top.sv
  - target: test
    files:
      - verification/cipher_core_model.sv
      - verification/cbc_dec_asserts.sv
      - verification/cbc_dec_tb.sv

// File: verification/cbc_dec_tb.sv
`timescale 1ns/1ps

module cbc_dec_tb import cbc_dec_pkg::*; ();

  localparam int N_TESTS   = 6;
  localparam int MAX_BLK   = 9;
  localparam int TIMEOUT   = 1000;
  localparam int STALL_CYC = 300;

  logic               clk = 1'b0;
  logic               reset_n;
  logic [WORD_W-1:0]  key_tdata;
  logic               key_tvalid;
  logic               key_tready;
  logic [WORD_W-1:0]  ct_tdata;
  logic               ct_tvalid;
  logic               ct_tready;
  logic               ct_tlast;
  logic [WORD_W-1:0]  pt_tdata;
  logic               pt_tvalid;
  logic               pt_tready;
  logic               pt_tlast;
  logic [N_CORES-1:0] core_cs;
  logic [N_CORES-1:0] core_we;
  logic [ADDR_W-1:0]  core_address    [N_CORES];
  logic [WORD_W-1:0]  core_write_data [N_CORES];
  logic [WORD_W-1:0]  core_read_data  [N_CORES];

  int errors = 0;
  int checks = 0;

  // --------------------------------------------------
  // test table with blocks as {word0, word1} in stream order
  // ready mode 0 always high, 1 random, 2 held low for the
  // first STALL_CYC cycles and then low two of five cycles
  // --------------------------------------------------
  logic [BLOCK_W-1:0] tbl_key [N_TESTS] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'h2b7e151628aed2a6abf7158809cf4f3c,
    128'hffeeddccbbaa99887766554433221100, 128'h603deb1015ca71be2b73aef0857d7781,
    128'h8e73b0f7da0e6452c810f32b809079e5, 128'h1f352c073b6108d72d9810a30914dff4
  };
  logic [BLOCK_W-1:0] tbl_iv [N_TESTS] = '{
    128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff, 128'h000102030405060708090a0b0c0d0e0f,
    128'h7649abac8119b246cee98e9b12e9197d, 128'h5086cb9b507219ee95db113a917678b2,
    128'h73bed6b8e3c1743b7116e69e22229516, 128'h3ff1caa1681fac09120eca307586e1a7
  };
  logic [WORD_W-1:0] tbl_ct_seed [N_TESTS] = '{
    64'h6bc1bee22e409f96, 64'hae2d8a571e03ac9c, 64'h30c81c46a35ce411,
    64'hf69f2445df4f9b17, 64'h9ac2a4d6c1f08e35, 64'h4be7d0a3127f5c68
  };
  int tbl_nblk  [N_TESTS] = '{1, 5, 4, 8, 9, 3};
  int tbl_ready [N_TESTS] = '{0, 0, 2, 0, 1, 1};

  logic [BLOCK_W-1:0] ct_blocks [MAX_BLK];
  logic [WORD_W-1:0]  exp_words [2*MAX_BLK];

  always #2 clk = ~clk;

  cbc_dec_top u_dut (
    .clk             (clk),
    .reset_n         (reset_n),
    .key_tdata       (key_tdata),
    .key_tvalid      (key_tvalid),
    .key_tready      (key_tready),
    .ct_tdata        (ct_tdata),
    .ct_tvalid       (ct_tvalid),
    .ct_tready       (ct_tready),
    .ct_tlast        (ct_tlast),
    .pt_tdata        (pt_tdata),
    .pt_tvalid       (pt_tvalid),
    .pt_tready       (pt_tready),
    .pt_tlast        (pt_tlast),
    .core_cs         (core_cs),
    .core_we         (core_we),
    .core_address    (core_address),
    .core_write_data (core_write_data),
    .core_read_data  (core_read_data)
  );

  for (genvar i = 0; i < N_CORES; i++) begin : g_core
    cipher_core_model u_core (
      .clk        (clk),
      .reset_n    (reset_n),
      .cs         (core_cs[i]),
      .we         (core_we[i]),
      .address    (core_address[i]),
      .write_data (core_write_data[i]),
      .read_data  (core_read_data[i])
    );
  end

  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [BLOCK_W-1:0] gen_ct_block(input logic [WORD_W-1:0] seed,
                                                      input int idx);
    logic [WORD_W-1:0] hi;
    logic [WORD_W-1:0] lo;
    hi = seed ^ (64'h9e3779b97f4a7c15 * 64'(idx + 1));
    lo = {hi[31:0], hi[63:32]} + 64'(idx);
    return {hi, lo};
  endfunction

  // long initial stall fills both skid entries and holds off result reads
  function automatic logic ready_pattern(input int mode, input int cyc);
    case (mode)
      1:       return ($urandom % 3) != 0;
      2:       return (cyc > STALL_CYC) && ((cyc % 5) >= 2);
      default: return 1'b1;
    endcase
  endfunction

  // --------------------------------------------------
  // stream drivers entered 1 ns after a rising edge
  // --------------------------------------------------
  task automatic send_key_word(input logic [WORD_W-1:0] data);
    int cyc;
    cyc        = 0;
    key_tdata  = data;
    key_tvalid = 1'b1;
    while (!key_tready && cyc < TIMEOUT) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (!key_tready) begin
      errors++;
      $display("key_tready never rose within %0d cycles", TIMEOUT);
    end
    @(posedge clk);
    #1;
    key_tvalid = 1'b0;
  endtask

  task automatic send_ct_word(input logic [WORD_W-1:0] data, input logic last);
    int cyc;
    cyc       = 0;
    ct_tdata  = data;
    ct_tlast  = last;
    ct_tvalid = 1'b1;
    while (!ct_tready && cyc < TIMEOUT) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (!ct_tready) begin
      errors++;
      $display("ct_tready never rose within %0d cycles", TIMEOUT);
    end
    @(posedge clk);
    #1;
    ct_tvalid = 1'b0;
    ct_tlast  = 1'b0;
  endtask

  task automatic drive_message(input int t);
    int n;
    n = tbl_nblk[t];
    send_key_word(tbl_key[t][BLOCK_W-1 -: WORD_W]);
    send_key_word(tbl_key[t][WORD_W-1:0]);
    send_ct_word(tbl_iv[t][BLOCK_W-1 -: WORD_W], 1'b0);
    send_ct_word(tbl_iv[t][WORD_W-1:0], 1'b0);
    for (int i = 0; i < n; i++) begin
      send_ct_word(ct_blocks[i][BLOCK_W-1 -: WORD_W], 1'b0);
      send_ct_word(ct_blocks[i][WORD_W-1:0], i == n - 1);
    end
  endtask

  // a beat seen here transfers on the next rising edge
  task automatic collect_output(input int nwords, input int mode);
    int got;
    int idle;
    int cyc;
    got  = 0;
    idle = 0;
    cyc  = 0;
    while (got < nwords && idle < TIMEOUT) begin
      @(posedge clk);
      #1;
      cyc++;
      pt_tready = ready_pattern(mode, cyc);
      if (pt_tvalid && pt_tready) begin
        check_value($sformatf("pt_tdata[%0d]", got), pt_tdata, exp_words[got]);
        check_value($sformatf("pt_tlast[%0d]", got), 64'(pt_tlast), 64'(got == nwords - 1));
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < nwords) begin
      errors++;
      $display("only %0d of %0d plaintext words arrived before the timeout", got, nwords);
    end
  endtask

  // nothing may follow the last word
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      pt_tready = 1'b1;
      check_value("pt_tvalid", 64'(pt_tvalid), 64'd0);
    end
  endtask

  initial begin
    int n;
    int errors_before;
    logic [BLOCK_W-1:0] prev;
    logic [BLOCK_W-1:0] plain;

    void'($urandom(32'h65cb));
    reset_n    = 1'b0;
    key_tdata  = '0;
    key_tvalid = 1'b0;
    ct_tdata   = '0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
    pt_tready  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // quiet after reset with no input
    repeat (10) begin
      @(posedge clk);
      #1;
      check_value("key_tready", 64'(key_tready), 64'd0);
      check_value("ct_tready", 64'(ct_tready), 64'd0);
      check_value("pt_tvalid", 64'(pt_tvalid), 64'd0);
    end

    for (int t = 0; t < N_TESTS; t++) begin
      errors_before = errors;
      n             = tbl_nblk[t];
      prev          = tbl_iv[t];
      // byte swaps inside the DUT cancel out under xor
      for (int i = 0; i < n; i++) begin
        ct_blocks[i]     = gen_ct_block(tbl_ct_seed[t], i);
        plain            = (ct_blocks[i] ^ tbl_key[t]) ^ prev;
        exp_words[2*i]   = plain[BLOCK_W-1 -: WORD_W];
        exp_words[2*i+1] = plain[WORD_W-1:0];
        prev             = ct_blocks[i];
      end
      fork
        drive_message(t);
        collect_output(2 * n, tbl_ready[t]);
      join
      check_idle(8);
      $display("test %0d: %0d blocks, ready mode %0d, %0d errors",
               t, n, tbl_ready[t], errors - errors_before);
    end

    errors += u_dut.u_asserts.assert_fails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             N_TESTS, checks, errors, u_dut.u_asserts.assert_fails);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/cbc_dec_asserts.sv
`timescale 1ns/1ps

module cbc_dec_asserts import cbc_dec_pkg::*; (
  input logic               clk,
  input logic               reset_n,
  input logic [N_CORES-1:0] core_cs,
  input logic [N_CORES-1:0] core_we,
  input logic [WORD_W-1:0]  pt_tdata,
  input logic               pt_tvalid,
  input logic               pt_tready,
  input logic               pt_tlast,
  input core_op_e           op,
  input logic               op_broadcast
);

  int assert_fails = 0;

  we_needs_cs: assert property (@(posedge clk) disable iff (!reset_n)
    ((core_we & ~core_cs) == '0))
  else begin
    assert_fails++;
    $error("core_we high on a core without core_cs");
  end

  // output word held while stalled
  pt_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (pt_tvalid && !pt_tready) |=> (pt_tvalid && $stable(pt_tdata) && $stable(pt_tlast)))
  else begin
    assert_fails++;
    $error("pt stream changed while stalled");
  end

  // bus outputs are registered, so cs follows op by one cycle
  one_reader: assert property (@(posedge clk) disable iff (!reset_n)
    (op == OP_RESULT_RD && !op_broadcast) |=> $onehot0(core_cs))
  else begin
    assert_fails++;
    $error("more than one core selected during a result read");
  end

endmodule

bind cbc_dec_top cbc_dec_asserts u_asserts (
  .clk          (clk),
  .reset_n      (reset_n),
  .core_cs      (core_cs),
  .core_we      (core_we),
  .pt_tdata     (pt_tdata),
  .pt_tvalid    (pt_tvalid),
  .pt_tready    (pt_tready),
  .pt_tlast     (pt_tlast),
  .op           (op),
  .op_broadcast (op_broadcast)
);

// File: verification/cipher_core_model.sv
`timescale 1ns/1ps

module cipher_core_model import cbc_dec_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              cs,
  input  logic              we,
  input  logic [ADDR_W-1:0] address,
  input  logic [WORD_W-1:0] write_data,
  output logic [WORD_W-1:0] read_data
);

  logic [WORD_W-1:0] key_reg    [2];
  logic [WORD_W-1:0] block_reg  [2];
  logic [WORD_W-1:0] result_reg [2];
  logic              ready;
  logic              ctrl_hold;
  int                busy_cnt;
  core_word_u        wr_word;
  core_word_u        status_word;

  assign wr_word.raw = write_data;

  always_comb begin
    status_word.raw              = '0;
    status_word.flags.init_ready = ready;
  end

  always @(posedge clk) begin
    if (!reset_n) begin
      ready     <= 1'b0;
      ctrl_hold <= 1'b0;
      busy_cnt  <= 0;
      read_data <= '0;
    end else begin
      // a held control write only counts once
      ctrl_hold <= cs && we && (address == ADDR_CTRL);
      if (busy_cnt > 1) begin
        busy_cnt <= busy_cnt - 1;
      end else if (busy_cnt == 1) begin
        busy_cnt <= 0;
        ready    <= 1'b1;
      end

      if (cs && we) begin
        case (address)
          ADDR_KEY0:          key_reg[0]   <= write_data;
          ADDR_KEY0 + 8'd1:   key_reg[1]   <= write_data;
          ADDR_BLOCK0:        block_reg[0] <= write_data;
          ADDR_BLOCK0 + 8'd1: block_reg[1] <= write_data;
          ADDR_CTRL: begin
            if (!ctrl_hold) begin
              ready <= 1'b0;
              if (wr_word.flags.init_ready) begin
                busy_cnt <= 60;
              end else if (wr_word.flags.next) begin
                // stand-in cipher: block xor key
                result_reg[0] <= block_reg[0] ^ key_reg[0];
                result_reg[1] <= block_reg[1] ^ key_reg[1];
                busy_cnt      <= 12 + int'($urandom % 19);
              end
            end
          end
          default: ;
        endcase
      end

      if (cs && !we) begin
        case (address)
          ADDR_STATUS:         read_data <= status_word.raw;
          ADDR_RESULT0:        read_data <= result_reg[0];
          ADDR_RESULT0 + 8'd1: read_data <= result_reg[1];
          default:             read_data <= '0;
        endcase
      end
    end
  end

endmodule

// File: verilog/cbc_dec_top.sv
`timescale 1ns/1ps

module cbc_dec_top import cbc_dec_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic [WORD_W-1:0]  key_tdata,
  input  logic               key_tvalid,
  output logic               key_tready,
  input  logic [WORD_W-1:0]  ct_tdata,
  input  logic               ct_tvalid,
  output logic               ct_tready,
  input  logic               ct_tlast,
  output logic [WORD_W-1:0]  pt_tdata,
  output logic               pt_tvalid,
  input  logic               pt_tready,
  output logic               pt_tlast,
  output logic [N_CORES-1:0] core_cs,
  output logic [N_CORES-1:0] core_we,
  output logic [ADDR_W-1:0]  core_address    [N_CORES],
  output logic [WORD_W-1:0]  core_write_data [N_CORES],
  input  logic [WORD_W-1:0]  core_read_data  [N_CORES]
);

  logic               store_key;
  logic               store_iv;
  logic               store_ct;
  logic               update_iv0;
  logic               word_idx;
  logic [SLOT_W-1:0]  load_slot;
  logic [SLOT_W-1:0]  out_slot;
  core_op_e           op;
  logic               op_broadcast;
  logic               out_valid;
  logic               out_last;
  logic               out_ready;
  logic               core_ready;
  logic [BLOCK_W-1:0] key_block;
  logic [BLOCK_W-1:0] ct_block;
  logic [BLOCK_W-1:0] slot_iv [N_CORES];
  logic [WORD_W-1:0]  pt_word;

  cbc_dec_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .key_tvalid   (key_tvalid),
    .ct_tvalid    (ct_tvalid),
    .ct_tlast     (ct_tlast),
    .core_ready   (core_ready),
    .out_ready    (out_ready),
    .key_tready   (key_tready),
    .ct_tready    (ct_tready),
    .store_key    (store_key),
    .store_iv     (store_iv),
    .store_ct     (store_ct),
    .update_iv0   (update_iv0),
    .word_idx     (word_idx),
    .load_slot    (load_slot),
    .out_slot     (out_slot),
    .op           (op),
    .op_broadcast (op_broadcast),
    .out_valid    (out_valid),
    .out_last     (out_last)
  );

  block_capture u_capture (
    .clk        (clk),
    .key_tdata  (key_tdata),
    .ct_tdata   (ct_tdata),
    .store_key  (store_key),
    .store_iv   (store_iv),
    .store_ct   (store_ct),
    .update_iv0 (update_iv0),
    .word_idx   (word_idx),
    .load_slot  (load_slot),
    .key_block  (key_block),
    .ct_block   (ct_block),
    .slot_iv    (slot_iv)
  );

  core_bus_drive u_bus (
    .clk             (clk),
    .reset_n         (reset_n),
    .op              (op),
    .op_broadcast    (op_broadcast),
    .slot            (load_slot),
    .word_idx        (word_idx),
    .key_block       (key_block),
    .ct_block        (ct_block),
    .core_cs         (core_cs),
    .core_we         (core_we),
    .core_address    (core_address),
    .core_write_data (core_write_data)
  );

  cbc_unchain u_unchain (
    .core_read_data (core_read_data),
    .slot_iv        (slot_iv),
    .out_slot       (out_slot),
    .word_idx       (word_idx),
    .core_ready     (core_ready),
    .pt_word        (pt_word)
  );

  pt_skid_buffer u_skid (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_data   (pt_word),
    .in_valid  (out_valid),
    .in_last   (out_last),
    .pt_tready (pt_tready),
    .out_ready (out_ready),
    .pt_tdata  (pt_tdata),
    .pt_tvalid (pt_tvalid),
    .pt_tlast  (pt_tlast)
  );

endmodule

// File: verilog/pt_skid_buffer.sv
`timescale 1ns/1ps

module pt_skid_buffer import cbc_dec_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [WORD_W-1:0] in_data,
  input  logic              in_valid,
  input  logic              in_last,
  input  logic              pt_tready,
  output logic              out_ready,
  output logic [WORD_W-1:0] pt_tdata,
  output logic              pt_tvalid,
  output logic              pt_tlast
);

  logic [WORD_W-1:0] spare_data;
  logic              spare_last;
  logic              spare_valid;
  logic              main_free;
  logic              in_fire;

  assign out_ready = !spare_valid;
  assign in_fire   = in_valid && out_ready;
  assign main_free = pt_tready || !pt_tvalid;

  // spare drains ahead of new input
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spare_valid) begin
        pt_tdata <= spare_data;
        pt_tlast <= spare_last;
      end else if (in_fire) begin
        pt_tdata <= in_data;
        pt_tlast <= in_last;
      end
    end else if (in_fire) begin
      spare_data <= in_data;
      spare_last <= in_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pt_tvalid   <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      pt_tvalid   <= spare_valid || in_fire;
      spare_valid <= 1'b0;
    end else if (in_fire) begin
      spare_valid <= 1'b1;
    end
  end

endmodule

// File: verilog/cbc_unchain.sv
`timescale 1ns/1ps

module cbc_unchain import cbc_dec_pkg::*; (
  input  logic [WORD_W-1:0]  core_read_data [N_CORES],
  input  logic [BLOCK_W-1:0] slot_iv        [N_CORES],
  input  logic [SLOT_W-1:0]  out_slot,
  input  logic               word_idx,
  output logic               core_ready,
  output logic [WORD_W-1:0]  pt_word
);

  core_word_u         rd_word;
  logic [BLOCK_W-1:0] iv;
  logic [WORD_W-1:0]  iv_half;
  logic [WORD_W-1:0]  plain;

  assign rd_word.raw = core_read_data[out_slot];
  assign core_ready  = rd_word.flags.init_ready;

  // undo the chaining with the previous block or the iv
  assign iv      = slot_iv[out_slot];
  assign iv_half = word_idx ? iv[WORD_W-1:0] : iv[BLOCK_W-1 -: WORD_W];
  assign plain   = rd_word.raw ^ iv_half;

  // back to stream byte order
  assign pt_word = {<<8{plain}};

endmodule

// File: verilog/core_bus_drive.sv
`timescale 1ns/1ps

module core_bus_drive import cbc_dec_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  core_op_e           op,
  input  logic               op_broadcast,
  input  logic [SLOT_W-1:0]  slot,
  input  logic               word_idx,
  input  logic [BLOCK_W-1:0] key_block,
  input  logic [BLOCK_W-1:0] ct_block,
  output logic [N_CORES-1:0] core_cs,
  output logic [N_CORES-1:0] core_we,
  output logic [ADDR_W-1:0]  core_address    [N_CORES],
  output logic [WORD_W-1:0]  core_write_data [N_CORES]
);

  logic [ADDR_W-1:0]  addr_d;
  core_word_u         data_d;
  logic               is_write;
  logic [N_CORES-1:0] sel;

  always_comb begin
    addr_d     = ADDR_STATUS;
    data_d.raw = '0;
    is_write   = 1'b1;
    case (op)
      OP_KEY_WR: begin
        addr_d     = ADDR_KEY0 + ADDR_W'(word_idx);
        data_d.raw = word_idx ? key_block[WORD_W-1:0] : key_block[BLOCK_W-1 -: WORD_W];
      end
      OP_BLOCK_WR: begin
        addr_d     = ADDR_BLOCK0 + ADDR_W'(word_idx);
        data_d.raw = word_idx ? ct_block[WORD_W-1:0] : ct_block[BLOCK_W-1 -: WORD_W];
      end
      OP_INIT: begin
        addr_d                 = ADDR_CTRL;
        data_d.flags.init_ready = 1'b1;
      end
      OP_NEXT: begin
        addr_d            = ADDR_CTRL;
        data_d.flags.next = 1'b1;
      end
      OP_STATUS_RD: begin
        addr_d   = ADDR_STATUS;
        is_write = 1'b0;
      end
      // result address follows the word index
      OP_RESULT_RD: begin
        addr_d   = ADDR_RESULT0 + ADDR_W'(word_idx);
        is_write = 1'b0;
      end
      default: begin
        is_write = 1'b0;
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < N_CORES; i++) begin
      sel[i] = (op != OP_NONE) && (op_broadcast || slot == SLOT_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_CORES; i++) begin
      if (sel[i]) begin
        core_address[i]    <= addr_d;
        core_write_data[i] <= data_d.raw;
      end
    end

    if (!reset_n) begin
      core_cs <= '0;
      core_we <= '0;
    end else begin
      core_cs <= sel;
      core_we <= sel & {N_CORES{is_write}};
    end
  end

endmodule

// File: verilog/block_capture.sv
`timescale 1ns/1ps

module block_capture import cbc_dec_pkg::*; (
  input  logic               clk,
  input  logic [WORD_W-1:0]  key_tdata,
  input  logic [WORD_W-1:0]  ct_tdata,
  input  logic               store_key,
  input  logic               store_iv,
  input  logic               store_ct,
  input  logic               update_iv0,
  input  logic               word_idx,
  input  logic [SLOT_W-1:0]  load_slot,
  output logic [BLOCK_W-1:0] key_block,
  output logic [BLOCK_W-1:0] ct_block,
  output logic [BLOCK_W-1:0] slot_iv [N_CORES]
);

  logic [WORD_W-1:0]          key_word;
  logic [WORD_W-1:0]          ct_word;
  logic [BLOCK_W-1:0]         iv_pending;
  logic [SLOT_W-1:0]          next_slot;
  logic [$clog2(BLOCK_W)-1:0] half_lo;

  // stream byte 0 is the msb of the half
  assign key_word  = {<<8{key_tdata}};
  assign ct_word   = {<<8{ct_tdata}};
  assign next_slot = load_slot + 1'b1;

  // first word is the upper half
  assign half_lo = word_idx ? '0 : ($clog2(BLOCK_W))'(WORD_W);

  always_ff @(posedge clk) begin
    if (store_key) begin
      key_block[half_lo +: WORD_W] <= key_word;
    end

    if (store_ct) begin
      ct_block[half_lo +: WORD_W] <= ct_word;
      // this block chains into the next slot
      if (load_slot == SLOT_W'(N_CORES - 1)) begin
        iv_pending[half_lo +: WORD_W] <= ct_word;
      end else begin
        slot_iv[next_slot][half_lo +: WORD_W] <= ct_word;
      end
    end

    // slot 0 keeps its vector until its result has been read
    if (store_iv) begin
      slot_iv[0][half_lo +: WORD_W] <= ct_word;
    end else if (update_iv0) begin
      slot_iv[0] <= iv_pending;
    end
  end

endmodule

// File: verilog/cbc_dec_ctrl.sv
`timescale 1ns/1ps

module cbc_dec_ctrl import cbc_dec_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              key_tvalid,
  input  logic              ct_tvalid,
  input  logic              ct_tlast,
  input  logic              core_ready,
  input  logic              out_ready,
  output logic              key_tready,
  output logic              ct_tready,
  output logic              store_key,
  output logic              store_iv,
  output logic              store_ct,
  output logic              update_iv0,
  output logic              word_idx,
  output logic [SLOT_W-1:0] load_slot,
  output logic [SLOT_W-1:0] out_slot,
  output core_op_e          op,
  output logic              op_broadcast,
  output logic              out_valid,
  output logic              out_last
);

  logic [3:0]        state_q, state_d;
  logic              word_q, word_d;
  logic [1:0]        wr_q, wr_d;
  logic [WAIT_W-1:0] wait_q, wait_d;
  logic [SLOT_W-1:0] load_ptr_q, load_ptr_d;
  logic [SLOT_W-1:0] out_ptr_q, out_ptr_d;
  logic              last_q, last_d;
  logic [SLOT_W-1:0] last_slot_q, last_slot_d;
  logic              wr_done;
  logic              key_beat;
  logic              ct_beat;

  assign key_tready = (state_q == ST_READ_KEY);
  assign ct_tready  = (state_q == ST_READ_IV) || (state_q == ST_READ_CT);
  assign key_beat   = key_tvalid && key_tready;
  assign ct_beat    = ct_tvalid && ct_tready;
  assign wr_done    = (wr_q == 2'(WAIT_WRITE));
  assign word_idx   = word_q;
  assign out_slot   = out_ptr_q;

  // bus target follows the read pointer while polling and reading results
  assign load_slot = (state_q inside {ST_WAIT_DEC, ST_READ_OUT}) ? out_ptr_q : load_ptr_q;

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_d      = state_q;
    word_d       = word_q;
    wr_d         = wr_q;
    wait_d       = wait_q;
    load_ptr_d   = load_ptr_q;
    out_ptr_d    = out_ptr_q;
    last_d       = last_q;
    last_slot_d  = last_slot_q;
    store_key    = 1'b0;
    store_iv     = 1'b0;
    store_ct     = 1'b0;
    update_iv0   = 1'b0;
    op           = OP_NONE;
    op_broadcast = 1'b0;
    out_valid    = 1'b0;
    out_last     = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (key_tvalid) begin
          word_d  = 1'b0;
          state_d = ST_READ_KEY;
        end
      end
      ST_READ_KEY: begin
        if (key_beat) begin
          store_key = 1'b1;
          word_d    = !word_q;
          if (word_q) begin
            state_d = ST_LOAD_KEY;
          end
        end
      end
      ST_LOAD_KEY: begin
        op           = OP_KEY_WR;
        op_broadcast = 1'b1;
        wr_d         = wr_done ? 2'd0 : wr_q + 2'd1;
        if (wr_done) begin
          word_d = !word_q;
          if (word_q) begin
            state_d = ST_START_KE;
          end
        end
      end
      ST_START_KE: begin
        op           = OP_INIT;
        op_broadcast = 1'b1;
        wr_d         = wr_done ? 2'd0 : wr_q + 2'd1;
        if (wr_done) begin
          state_d = ST_WAIT_PAYLOAD;
        end
      end
      ST_WAIT_PAYLOAD: begin
        if (ct_tvalid) begin
          state_d = ST_READ_IV;
        end
      end
      ST_READ_IV: begin
        if (ct_beat) begin
          store_iv = 1'b1;
          word_d   = !word_q;
          if (word_q) begin
            wait_d  = '0;
            state_d = ST_WAIT_KE;
          end
        end
      end
      // key expansion polled on core 0 only
      ST_WAIT_KE: begin
        op = OP_STATUS_RD;
        if (wait_q == WAIT_W'(WAIT_KE)) begin
          if (core_ready) begin
            state_d = ST_READ_CT;
          end
        end else begin
          wait_d = wait_q + 1'b1;
        end
      end
      ST_READ_CT: begin
        if (ct_beat) begin
          store_ct = 1'b1;
          word_d   = !word_q;
          if (word_q) begin
            last_d  = ct_tlast;
            state_d = ST_LOAD_CT;
          end
        end
      end
      ST_LOAD_CT: begin
        op   = OP_BLOCK_WR;
        wr_d = wr_done ? 2'd0 : wr_q + 2'd1;
        if (wr_done) begin
          word_d = !word_q;
          if (word_q) begin
            state_d = ST_START_DEC;
          end
        end
      end
      ST_START_DEC: begin
        op   = OP_NEXT;
        wr_d = wr_done ? 2'd0 : wr_q + 2'd1;
        if (wr_done) begin
          load_ptr_d = load_ptr_q + 1'b1;
          if (last_q) begin
            last_slot_d = load_ptr_q;
          end
          // batch full or message done
          if (load_ptr_q == SLOT_W'(N_CORES - 1) || last_q) begin
            wait_d  = '0;
            state_d = ST_WAIT_DEC;
          end else begin
            state_d = ST_READ_CT;
          end
        end
      end
      ST_WAIT_DEC: begin
        op = OP_STATUS_RD;
        if (wait_q == WAIT_W'(WAIT_DEC)) begin
          if (core_ready) begin
            wait_d  = '0;
            state_d = ST_READ_OUT;
          end
        end else begin
          wait_d = wait_q + 1'b1;
        end
      end
      ST_READ_OUT: begin
        op = OP_RESULT_RD;
        // address goes out a cycle later, data one more after that
        if (wait_q != WAIT_W'(READ_DELAY)) begin
          wait_d = wait_q + 1'b1;
        end else if (out_ready) begin
          out_valid = 1'b1;
          wait_d    = '0;
          word_d    = !word_q;
          if (word_q) begin
            out_last   = last_q && (out_ptr_q == last_slot_q);
            update_iv0 = (out_ptr_q == '0);
            out_ptr_d  = out_ptr_q + 1'b1;
            if (out_last) begin
              load_ptr_d = '0;
              out_ptr_d  = '0;
              last_d     = 1'b0;
              state_d    = ST_IDLE;
            end else if (out_ptr_q == SLOT_W'(N_CORES - 1)) begin
              state_d = ST_READ_CT;
            end else begin
              state_d = ST_WAIT_DEC;
            end
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_q     <= ST_IDLE;
      word_q      <= 1'b0;
      wr_q        <= '0;
      wait_q      <= '0;
      load_ptr_q  <= '0;
      out_ptr_q   <= '0;
      last_q      <= 1'b0;
      last_slot_q <= '0;
    end else begin
      state_q     <= state_d;
      word_q      <= word_d;
      wr_q        <= wr_d;
      wait_q      <= wait_d;
      load_ptr_q  <= load_ptr_d;
      out_ptr_q   <= out_ptr_d;
      last_q      <= last_d;
      last_slot_q <= last_slot_d;
    end
  end

endmodule

// File: verilog/cbc_dec_pkg.sv
package cbc_dec_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int N_CORES = 4;
  localparam int SLOT_W  = 2;
  localparam int WORD_W  = 64;
  localparam int BLOCK_W = 128;
  localparam int ADDR_W  = 8;

  // core register map
  localparam logic [ADDR_W-1:0] ADDR_CTRL    = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_STATUS  = 8'h09;
  localparam logic [ADDR_W-1:0] ADDR_KEY0    = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_BLOCK0  = 8'h20;
  localparam logic [ADDR_W-1:0] ADDR_RESULT0 = 8'h30;

  localparam int CTRL_INIT_BIT    = 0;
  localparam int CTRL_NEXT_BIT    = 1;
  localparam int STATUS_READY_BIT = 0;

  // wait counts
  localparam int WAIT_WRITE = 2;
  localparam int WAIT_KE    = 50;
  localparam int WAIT_DEC   = 10;
  localparam int READ_DELAY = 2;
  localparam int WAIT_W     = $clog2(WAIT_KE + 1);

  // controller states
  localparam logic [3:0] ST_IDLE         = 4'd0;
  localparam logic [3:0] ST_READ_KEY     = 4'd1;
  localparam logic [3:0] ST_LOAD_KEY     = 4'd2;
  localparam logic [3:0] ST_START_KE     = 4'd3;
  localparam logic [3:0] ST_WAIT_PAYLOAD = 4'd4;
  localparam logic [3:0] ST_READ_IV      = 4'd5;
  localparam logic [3:0] ST_WAIT_KE      = 4'd6;
  localparam logic [3:0] ST_READ_CT      = 4'd7;
  localparam logic [3:0] ST_LOAD_CT      = 4'd8;
  localparam logic [3:0] ST_START_DEC    = 4'd9;
  localparam logic [3:0] ST_WAIT_DEC     = 4'd10;
  localparam logic [3:0] ST_READ_OUT     = 4'd11;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_KEY_WR,
    OP_INIT,
    OP_BLOCK_WR,
    OP_NEXT,
    OP_STATUS_RD,
    OP_RESULT_RD
  } core_op_e;

  // one bus word, as data or as control/status flags
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      logic [WORD_W-3:0] pad;
      logic              next;
      logic              init_ready;
    } flags;
  } core_word_u;

endpackage
